// File: build.f
common/mesh_pkg.sv
common/sync_pkg.sv
xbar/mesh_xbar.sv
src/l2_mem.sv
src/eoc_mailbox.sv
sync/sync_barrier.sv
src/mesh_uncore.sv
testbench/tb_mesh_uncore.sv

// File: common/mesh_pkg.sv
// Address map, bus widths and target region decode type for the uncore
`default_nettype none

package mesh_pkg;

  // Bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // L2 window, size set by the L2_WORDS module parameter
  localparam logic [ADDR_W-1:0] L2_BASE = 32'h1c00_0000;

  // Mailbox window
  localparam logic [ADDR_W-1:0] MBOX_BASE  = 32'h1fff_0000;
  localparam int unsigned       MBOX_WORDS = 32;
  localparam int unsigned       MBOX_IDX_W = $clog2(MBOX_WORDS);  // Word index width

  // Word index of the character port, exit codes sit at words 0..N_TILES-1
  localparam int unsigned CHAR_IDX = 16;

  // Returned for reads that hit no target
  localparam logic [DATA_W-1:0] BAD_RDATA = 32'hbadc_ab1e;

  // Target selected by the address decoder
  typedef enum logic [1:0] {
    REGION_L2,
    REGION_MBOX,
    REGION_NONE  // Unmapped, access flagged with err
  } mesh_region_e;

endpackage

`default_nettype wire

// File: common/sync_pkg.sv
// Barrier scope and barrier group state types
`default_nettype none

package sync_pkg;

  // Scope requested by a tile together with sync
  typedef enum logic {
    LVL_PAIR,  // Tiles 2k and 2k+1
    LVL_ALL    // Every tile
  } sync_lvl_e;

  // Per-group state inside the barrier
  typedef enum logic {
    S_IDLE,  // Waiting for arrivals
    S_WAKE   // Wake pulse to members
  } sync_state_e;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build the uncore testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_mesh_uncore -o sim_mesh_uncore \
  && ./obj_dir/sim_mesh_uncore | tee /dev/stderr | grep -q "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: src/eoc_mailbox.sv
// Exit-code mailbox with all-done flag and tagged character output
`timescale 1ns/10ps
`default_nettype none

module eoc_mailbox #(
  parameter int unsigned N_TILES = 4
) (
  input  wire                                clk,
  input  wire                                rst_n_i,
  input  wire                                en_i,
  input  wire                                we_i,
  input  wire  [mesh_pkg::MBOX_IDX_W-1:0]    idx_i,         // Mailbox word
  input  wire  [mesh_pkg::DATA_W-1:0]        wdata_i,
  input  wire  [$clog2(N_TILES)-1:0]         tile_i,        // Granted tile
  output logic [mesh_pkg::DATA_W-1:0]        rdata_o,
  output logic [N_TILES*8-1:0]               exit_codes_o,  // Tile 0 in low byte
  output logic                               eoc_o,
  output logic                               char_valid_o,
  output logic [7:0]                         char_o,
  output logic [$clog2(N_TILES)-1:0]         char_tile_o
);

  localparam int unsigned TW    = $clog2(N_TILES);
  localparam int unsigned IDX_W = mesh_pkg::MBOX_IDX_W;

  logic [N_TILES-1:0][7:0] codes_q;  // One exit code per tile
  logic                    code_hit;  // Index is an exit code word
  logic                    char_hit;
  logic                    all_nz;

  assign code_hit = idx_i < IDX_W'(N_TILES);
  assign char_hit = idx_i == IDX_W'(mesh_pkg::CHAR_IDX);

  // Done when every tile has posted a nonzero code
  always_comb begin
    all_nz = 1'b1;
    for (int i = 0; i < int'(N_TILES); i++) begin
      if (codes_q[i] == 8'h00) all_nz = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      codes_q      <= '0;
      eoc_o        <= 1'b0;
      char_valid_o <= 1'b0;
    end else begin
      if (en_i && we_i && code_hit) codes_q[idx_i[TW-1:0]] <= wdata_i[7:0];
      eoc_o        <= all_nz;                  // One cycle behind the last code
      char_valid_o <= en_i && we_i && char_hit;  // Single-cycle strobe
    end
  end

  // Character payload and readback data
  always_ff @(posedge clk) begin
    if (en_i && we_i && char_hit) begin
      char_o      <= wdata_i[7:0];
      char_tile_o <= tile_i;
    end
    if (en_i && !we_i) begin
      rdata_o <= code_hit ? {24'h0, codes_q[idx_i[TW-1:0]]} : '0;  // Others read zero
    end
  end

  assign exit_codes_o = codes_q;

endmodule

`default_nettype wire

// File: src/l2_mem.sv
// Single-port L2 word memory with registered read data
`timescale 1ns/10ps
`default_nettype none

module l2_mem #(
  parameter int unsigned L2_WORDS = 256
) (
  input  wire                               clk,
  input  wire                               en_i,     // Access strobe
  input  wire                               we_i,     // 1 write, 0 read
  input  wire  [$clog2(L2_WORDS)-1:0]       addr_i,   // Word index
  input  wire  [mesh_pkg::DATA_W-1:0]       wdata_i,
  output logic [mesh_pkg::DATA_W-1:0]       rdata_o   // Valid the cycle after a read
);

  // Storage array
  logic [mesh_pkg::DATA_W-1:0] mem_q [L2_WORDS];

  // Write port
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  // Read port, output holds between reads
  always_ff @(posedge clk) begin
    if (en_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

// File: src/mesh_uncore.sv
// Uncore top level with crossbar, L2 memory, mailbox and barrier network
`timescale 1ns/10ps
`default_nettype none

module mesh_uncore #(
  parameter int unsigned N_TILES  = 4,
  parameter int unsigned L2_WORDS = 256
) (
  input  wire                                         clk,
  input  wire                                         rst_n_i,
  // Tile requests
  input  wire  [N_TILES-1:0]                          tile_req_i,
  input  wire  [N_TILES-1:0]                          tile_we_i,
  input  wire  [N_TILES-1:0][mesh_pkg::ADDR_W-1:0]    tile_addr_i,
  input  wire  [N_TILES-1:0][mesh_pkg::DATA_W-1:0]    tile_wdata_i,
  output logic [N_TILES-1:0]                          tile_gnt_o,
  output logic [N_TILES-1:0]                          tile_rvalid_o,
  output logic [N_TILES-1:0][mesh_pkg::DATA_W-1:0]    tile_rdata_o,
  output logic [N_TILES-1:0]                          tile_err_o,
  // Barrier
  input  wire  [N_TILES-1:0]                          sync_i,
  input  sync_pkg::sync_lvl_e [N_TILES-1:0]           sync_lvl_i,
  output logic [N_TILES-1:0]                          wake_o,
  // End of computation and character output
  output logic [N_TILES*8-1:0]                        exit_codes_o,
  output logic                                        eoc_o,
  output logic                                        char_valid_o,
  output logic [7:0]                                  char_o,
  output logic [$clog2(N_TILES)-1:0]                  char_tile_o
);

  // Crossbar to L2
  logic                              mem_en;
  logic                              mem_we;
  logic [$clog2(L2_WORDS)-1:0]       mem_addr;
  logic [mesh_pkg::DATA_W-1:0]       mem_wdata;
  logic [mesh_pkg::DATA_W-1:0]       mem_rdata;
  // Crossbar to mailbox
  logic                              mbox_en;
  logic                              mbox_we;
  logic [mesh_pkg::MBOX_IDX_W-1:0]   mbox_idx;
  logic [mesh_pkg::DATA_W-1:0]       mbox_wdata;
  logic [$clog2(N_TILES)-1:0]        mbox_tile;
  logic [mesh_pkg::DATA_W-1:0]       mbox_rdata;

  mesh_xbar #(
    .N_TILES  (N_TILES),
    .L2_WORDS (L2_WORDS)
  ) i_mesh_xbar (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .tile_req_i    (tile_req_i),
    .tile_we_i     (tile_we_i),
    .tile_addr_i   (tile_addr_i),
    .tile_wdata_i  (tile_wdata_i),
    .tile_gnt_o    (tile_gnt_o),
    .tile_rvalid_o (tile_rvalid_o),
    .tile_rdata_o  (tile_rdata_o),
    .tile_err_o    (tile_err_o),
    .mem_en_o      (mem_en),
    .mem_we_o      (mem_we),
    .mem_addr_o    (mem_addr),
    .mem_wdata_o   (mem_wdata),
    .mem_rdata_i   (mem_rdata),
    .mbox_en_o     (mbox_en),
    .mbox_we_o     (mbox_we),
    .mbox_idx_o    (mbox_idx),
    .mbox_wdata_o  (mbox_wdata),
    .mbox_tile_o   (mbox_tile),
    .mbox_rdata_i  (mbox_rdata)
  );

  l2_mem #(
    .L2_WORDS (L2_WORDS)
  ) i_l2_mem (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  eoc_mailbox #(
    .N_TILES (N_TILES)
  ) i_eoc_mailbox (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .en_i         (mbox_en),
    .we_i         (mbox_we),
    .idx_i        (mbox_idx),
    .wdata_i      (mbox_wdata),
    .tile_i       (mbox_tile),
    .rdata_o      (mbox_rdata),
    .exit_codes_o (exit_codes_o),
    .eoc_o        (eoc_o),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .char_tile_o  (char_tile_o)
  );

  sync_barrier #(
    .N_TILES (N_TILES)
  ) i_sync_barrier (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .sync_i     (sync_i),
    .sync_lvl_i (sync_lvl_i),
    .wake_o     (wake_o)
  );

endmodule

`default_nettype wire

// File: sync/sync_barrier.sv
// Pair and global barrier groups producing wake pulses to their members
`timescale 1ns/10ps
`default_nettype none

module sync_barrier #(
  parameter int unsigned N_TILES = 4
) (
  input  wire                                   clk,
  input  wire                                   rst_n_i,
  input  wire  [N_TILES-1:0]                    sync_i,      // Held until wake
  input  sync_pkg::sync_lvl_e [N_TILES-1:0]     sync_lvl_i,  // Scope per tile
  output logic [N_TILES-1:0]                    wake_o
);

  localparam int unsigned N_PAIRS = N_TILES / 2;

  sync_pkg::sync_state_e [N_PAIRS-1:0] pair_state_q;
  sync_pkg::sync_state_e               glob_state_q;
  logic [N_PAIRS-1:0]                  pair_arr;   // Both pair members waiting
  logic                                glob_arr;   // Every tile waiting at LVL_ALL

  // Arrival only counts in S_IDLE, sync is still high during the wake cycle
  always_comb begin
    for (int k = 0; k < int'(N_PAIRS); k++) begin
      pair_arr[k] = (pair_state_q[k] == sync_pkg::S_IDLE) &&
                    sync_i[2*k] && sync_i[2*k+1] &&
                    (sync_lvl_i[2*k]   == sync_pkg::LVL_PAIR) &&
                    (sync_lvl_i[2*k+1] == sync_pkg::LVL_PAIR);
    end
    glob_arr = (glob_state_q == sync_pkg::S_IDLE);
    for (int i = 0; i < int'(N_TILES); i++) begin
      if (!sync_i[i] || sync_lvl_i[i] != sync_pkg::LVL_ALL) glob_arr = 1'b0;  // Mixed never completes
    end
  end

  // Group FSMs, S_WAKE lasts one cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pair_state_q <= {N_PAIRS{sync_pkg::S_IDLE}};
      glob_state_q <= sync_pkg::S_IDLE;
    end else begin
      for (int k = 0; k < int'(N_PAIRS); k++) begin
        if (pair_state_q[k] == sync_pkg::S_WAKE) pair_state_q[k] <= sync_pkg::S_IDLE;
        else if (pair_arr[k])                    pair_state_q[k] <= sync_pkg::S_WAKE;
      end
      if (glob_state_q == sync_pkg::S_WAKE) glob_state_q <= sync_pkg::S_IDLE;
      else if (glob_arr)                    glob_state_q <= sync_pkg::S_WAKE;
    end
  end

  // Wake straight from the state flops
  always_comb begin
    for (int i = 0; i < int'(N_TILES); i++) begin
      wake_o[i] = (pair_state_q[i/2] == sync_pkg::S_WAKE) ||
                  (glob_state_q == sync_pkg::S_WAKE);
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_mesh_uncore.sv
// Testbench for the mesh uncore with LFSR tile traffic, reference model and checks
`timescale 1ns/10ps
`default_nettype none

module tb_mesh_uncore;

  localparam int N = 4;

  logic                  clk;
  logic                  rst_n;
  logic [N-1:0]          tile_req;
  logic [N-1:0]          tile_we;
  logic [N-1:0][31:0]    tile_addr;
  logic [N-1:0][31:0]    tile_wdata;
  wire  [N-1:0]          tile_gnt;
  wire  [N-1:0]          tile_rvalid;
  wire  [N-1:0][31:0]    tile_rdata;
  wire  [N-1:0]          tile_err;
  logic [N-1:0]          sync;
  sync_pkg::sync_lvl_e [N-1:0] sync_lvl;
  wire  [N-1:0]          wake;
  wire  [N*8-1:0]        exit_codes;
  wire                   eoc;
  wire                   char_valid;
  wire  [7:0]            char_out;
  wire  [1:0]            char_tile;

  logic [31:0] lfsr_q = 32'hdaf0a5c3;
  logic [31:0] shadow_mem [256];     // Reference L2 contents
  logic        written [256];
  logic [9:0]  char_seen [$];        // {tile, char} from the monitor
  int          errors;
  int          test_errs;
  int          tests_run;
  int          tests_failed;

  mesh_uncore #(.N_TILES(N), .L2_WORDS(256)) i_mesh_uncore (
    .clk(clk), .rst_n_i(rst_n),
    .tile_req_i(tile_req), .tile_we_i(tile_we), .tile_addr_i(tile_addr),
    .tile_wdata_i(tile_wdata), .tile_gnt_o(tile_gnt), .tile_rvalid_o(tile_rvalid),
    .tile_rdata_o(tile_rdata), .tile_err_o(tile_err),
    .sync_i(sync), .sync_lvl_i(sync_lvl), .wake_o(wake),
    .exit_codes_o(exit_codes), .eoc_o(eoc), .char_valid_o(char_valid),
    .char_o(char_out), .char_tile_o(char_tile)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Character strobe monitor
  always @(negedge clk) begin
    if (char_valid) char_seen.push_back({char_tile, char_out});
  end

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] l2_addr(input int w);
    return 32'h1c00_0000 + 32'(w * 4);
  endfunction

  // Single tile request that starts and ends 1 ns after a rising edge
  task automatic access(input int t, input logic we, input logic [31:0] addr,
                        input logic [31:0] wd, output logic [31:0] rd, output logic err);
    int  n;
    bit  seen;
    n = 0;
    seen = 0;
    rd = '0;
    err = 1'b0;
    tile_req[t] = 1'b1;
    tile_we[t] = we;
    tile_addr[t] = addr;
    tile_wdata[t] = wd;
    while (!seen && n < 16) begin
      @(negedge clk);
      if (tile_gnt[t]) seen = 1;
      else n++;
    end
    @(posedge clk);
    #1;
    tile_req[t] = 1'b0;
    if (!seen) begin
      $display("ERROR: tile %0d received no grant within 16 cycles", t);
      test_errs++;
    end else begin
      @(negedge clk);
      if (tile_rvalid[t] !== !we) begin
        $display("mismatch at %0t: tile %0d rvalid %b one cycle after grant", $time, t,
                 tile_rvalid[t]);
        test_errs++;
      end
      rd = tile_rdata[t];
      err = tile_err[t];
      @(posedge clk);
      #1;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %0d %s: %s (%0d errors)", tests_run, name,
             test_errs == 0 ? "ok" : "failed", test_errs);
    errors += test_errs;
    test_errs = 0;
  endtask

  task automatic check_l2_words();
    logic [31:0] rd;
    logic        er;
    for (int w = 0; w < 256; w++) begin
      if (written[w]) begin
        access(w % N, 1'b0, l2_addr(w), '0, rd, er);
        if (rd !== shadow_mem[w] || er) begin
          $display("mismatch at %0t: L2 word %0d read %h err %b, expected %h", $time, w,
                   rd, er, shadow_mem[w]);
          test_errs++;
        end
      end
    end
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] wd;
    logic        er;
    int          t;
    int          w;
    int          waits [N];
    int          order [N];
    logic [7:0]  codes [N];
    logic [9:0]  exp_chars [$];
    int          delay [N];
    bit          member [N];
    int          wakes [N];
    int          last;
    int          tmp;
    errors = 0;
    test_errs = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    tile_req = '0;
    tile_we = '0;
    tile_addr = '0;
    tile_wdata = '0;
    sync = '0;
    for (int i = 0; i < N; i++) sync_lvl[i] = sync_pkg::LVL_PAIR;
    for (int i = 0; i < 256; i++) written[i] = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    // Random L2 traffic against the shadow array
    for (int i = 0; i < 200; i++) begin
      t = int'(rand_bits(2));
      w = int'(rand_bits(4));
      if (rand_bits(1) == 1) begin
        wd = rand_bits(32);
        access(t, 1'b1, l2_addr(w), wd, rd, er);
        shadow_mem[w] = wd;
        written[w] = 1'b1;
      end else begin
        access(t, 1'b0, l2_addr(w), '0, rd, er);
        if (written[w] && rd !== shadow_mem[w]) begin
          $display("mismatch at %0t: tile %0d word %0d read %h, expected %h", $time, t, w,
                   rd, shadow_mem[w]);
          test_errs++;
        end
      end
      if (er) begin
        $display("mismatch at %0t: tile %0d err set for L2 word %0d", $time, t, w);
        test_errs++;
      end
    end
    end_test("random L2 read/write");

    // All tiles writing continuously
    for (int i = 0; i < N; i++) begin
      waits[i] = 0;
      tile_we[i] = 1'b1;
      tile_addr[i] = l2_addr(100 + i);
      tile_wdata[i] = 32'h5a00_0000 + 32'(i);
    end
    tile_req = '1;
    for (int c = 0; c < 40; c++) begin
      @(negedge clk);
      if ($countones(tile_gnt) > 1) begin
        $display("mismatch at %0t: grants %b in one cycle", $time, tile_gnt);
        test_errs++;
      end
      for (int i = 0; i < N; i++) begin
        waits[i]++;
        if (waits[i] > N) begin
          $display("mismatch at %0t: tile %0d waited %0d cycles", $time, i, waits[i]);
          test_errs++;
        end
        if (tile_gnt[i]) waits[i] = 0;
      end
    end
    @(posedge clk);
    #1 tile_req = '0;
    for (int i = 0; i < N; i++) begin
      shadow_mem[100 + i] = 32'h5a00_0000 + 32'(i);
      written[100 + i] = 1'b1;
    end
    @(posedge clk);
    #1;
    check_l2_words();
    end_test("arbitration fairness");

    // Unmapped accesses above both windows
    for (int i = 0; i < 30; i++) begin
      t = int'(rand_bits(2));
      // Word bits land on L2 words 0 to 15
      wd = 32'h2000_0000 | {4'h0, 18'(rand_bits(18)), 4'h0, 4'(rand_bits(4)), 2'b00};
      access(t, rand_bits(1) == 1, wd, rand_bits(32), rd, er);
      if (!er) begin
        $display("mismatch at %0t: no err for address %h", $time, wd);
        test_errs++;
      end
      if (!tile_we[t] && rd !== 32'hbadc_ab1e) begin
        $display("mismatch at %0t: unmapped read gave %h", $time, rd);
        test_errs++;
      end
    end
    check_l2_words();
    end_test("unmapped accesses");

    // Character output in grant order
    char_seen.delete();
    for (int i = 0; i < 12; i++) begin
      t = int'(rand_bits(2));
      wd = rand_bits(32);
      exp_chars.push_back({2'(t), wd[7:0]});
      access(t, 1'b1, 32'h1fff_0000 + 32'd64, wd, rd, er);
    end
    repeat (3) @(posedge clk);
    #1;
    if (char_seen.size() != exp_chars.size()) begin
      $display("mismatch at %0t: %0d char pulses, expected %0d", $time, char_seen.size(),
               exp_chars.size());
      test_errs++;
    end else begin
      foreach (exp_chars[i]) begin
        if (char_seen[i] !== exp_chars[i]) begin
          $display("mismatch at %0t: char %0d is %h, expected %h", $time, i, char_seen[i],
                   exp_chars[i]);
          test_errs++;
        end
      end
    end
    end_test("character output");

    // Exit codes in shuffled order
    for (int i = 0; i < N; i++) order[i] = i;
    for (int i = N - 1; i > 0; i--) begin
      w = int'(rand_bits(2)) % (i + 1);
      tmp = order[i];
      order[i] = order[w];
      order[w] = tmp;
    end
    for (int i = 0; i < N; i++) codes[i] = 8'h00;
    for (int i = 0; i < N; i++) begin
      t = order[i];
      codes[t] = 8'(rand_bits(8)) | 8'h01;  // Nonzero
      access(t, 1'b1, 32'h1fff_0000 + 32'(t * 4), {24'h0, codes[t]}, rd, er);
      @(negedge clk);
      if (eoc !== (i == N - 1)) begin
        $display("mismatch at %0t: eoc %b after %0d codes", $time, eoc, i + 1);
        test_errs++;
      end
      @(posedge clk);
      #1;
    end
    for (int i = 0; i < N; i++) begin
      access(i, 1'b0, 32'h1fff_0000 + 32'(i * 4), '0, rd, er);
      if (rd !== {24'h0, codes[i]} || exit_codes[i*8 +: 8] !== codes[i]) begin
        $display("mismatch at %0t: tile %0d code read %h port %h, expected %h", $time, i,
                 rd, exit_codes[i*8 +: 8], codes[i]);
        test_errs++;
      end
    end
    end_test("exit codes");

    // Pair and global barriers with random arrival delays
    for (int r = 0; r < 20; r++) begin
      tmp = int'(rand_bits(2));  // Pair k below 2 and global above
      last = 0;
      for (int i = 0; i < N; i++) begin
        member[i] = tmp >= 2 || (i / 2 == tmp);
        sync_lvl[i] = tmp >= 2 ? sync_pkg::LVL_ALL : sync_pkg::LVL_PAIR;
        delay[i] = int'(rand_bits(3));
        wakes[i] = 0;
        if (member[i] && delay[i] > last) last = delay[i];
      end
      for (int c = 0; c < last + 5; c++) begin
        for (int i = 0; i < N; i++) begin
          if (member[i] && c == delay[i]) sync[i] = 1'b1;
        end
        @(negedge clk);
        for (int i = 0; i < N; i++) begin
          if (wake[i]) begin
            wakes[i]++;
            if (!member[i] || c != last + 1) begin
              $display("mismatch at %0t: tile %0d woke in cycle %0d, last arrival %0d",
                       $time, i, c, last);
              test_errs++;
            end
          end
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < N; i++) begin
          if (wakes[i] > 0) sync[i] = 1'b0;  // Leave after wake
        end
      end
      for (int i = 0; i < N; i++) begin
        if (member[i] && wakes[i] != 1) begin
          $display("mismatch at %0t: tile %0d saw %0d wake pulses in round %0d, expected 1",
                   $time, i, wakes[i], r);
          test_errs++;
        end
      end
      sync = '0;
    end
    end_test("barriers");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: xbar/mesh_xbar.sv
// Round-robin tile request crossbar with address decode and read return steering
`timescale 1ns/10ps
`default_nettype none

module mesh_xbar #(
  parameter int unsigned N_TILES  = 4,
  parameter int unsigned L2_WORDS = 256
) (
  input  wire                                            clk,
  input  wire                                            rst_n_i,
  // Tile side
  input  wire  [N_TILES-1:0]                             tile_req_i,
  input  wire  [N_TILES-1:0]                             tile_we_i,
  input  wire  [N_TILES-1:0][mesh_pkg::ADDR_W-1:0]       tile_addr_i,
  input  wire  [N_TILES-1:0][mesh_pkg::DATA_W-1:0]       tile_wdata_i,
  output logic [N_TILES-1:0]                             tile_gnt_o,
  output logic [N_TILES-1:0]                             tile_rvalid_o,
  output logic [N_TILES-1:0][mesh_pkg::DATA_W-1:0]       tile_rdata_o,
  output logic [N_TILES-1:0]                             tile_err_o,
  // L2 target
  output logic                                           mem_en_o,
  output logic                                           mem_we_o,
  output logic [$clog2(L2_WORDS)-1:0]                    mem_addr_o,
  output logic [mesh_pkg::DATA_W-1:0]                    mem_wdata_o,
  input  wire  [mesh_pkg::DATA_W-1:0]                    mem_rdata_i,
  // Mailbox target
  output logic                                           mbox_en_o,
  output logic                                           mbox_we_o,
  output logic [mesh_pkg::MBOX_IDX_W-1:0]                mbox_idx_o,
  output logic [mesh_pkg::DATA_W-1:0]                    mbox_wdata_o,
  output logic [$clog2(N_TILES)-1:0]                     mbox_tile_o,
  input  wire  [mesh_pkg::DATA_W-1:0]                    mbox_rdata_i
);

  localparam int unsigned AW    = mesh_pkg::ADDR_W;
  localparam int unsigned TW    = $clog2(N_TILES);
  localparam int unsigned MEM_W = $clog2(L2_WORDS);
  localparam int unsigned IDX_W = mesh_pkg::MBOX_IDX_W;

  // Window ends, exclusive
  localparam logic [AW-1:0] L2_END   = mesh_pkg::L2_BASE + AW'(L2_WORDS * 4);
  localparam logic [AW-1:0] MBOX_END = mesh_pkg::MBOX_BASE + AW'(mesh_pkg::MBOX_WORDS * 4);

  logic [TW-1:0]              rr_ptr_q;    // Last tile granted
  logic [TW-1:0]              cand;
  logic [TW-1:0]              gnt_idx;
  logic                       gnt_any;
  logic [AW-1:0]              sel_addr;
  logic [AW-1:0]              l2_off;
  logic [AW-1:0]              mbox_off;
  mesh_pkg::mesh_region_e     sel_region;

  // Return path state, one cycle behind the grant
  logic                       acc_q;       // Any access granted last cycle
  logic                       rd_q;        // That access was a read
  logic [TW-1:0]              ret_tile_q;
  mesh_pkg::mesh_region_e     ret_region_q;
  logic [mesh_pkg::DATA_W-1:0] ret_data;

  // Search starts one past the last winner, ends on the last winner itself
  always_comb begin
    gnt_any = 1'b0;
    gnt_idx = '0;
    cand    = '0;
    for (int k = 1; k <= int'(N_TILES); k++) begin
      cand = rr_ptr_q + TW'(k);  // Wraps since N_TILES is a power of two
      if (!gnt_any && tile_req_i[cand]) begin
        gnt_any = 1'b1;
        gnt_idx = cand;
      end
    end
  end

  assign tile_gnt_o = N_TILES'(gnt_any) << gnt_idx;  // One-hot pulse

  // Address decode of the winner
  assign sel_addr = tile_addr_i[gnt_idx];
  assign l2_off   = sel_addr - mesh_pkg::L2_BASE;
  assign mbox_off = sel_addr - mesh_pkg::MBOX_BASE;

  always_comb begin
    sel_region = mesh_pkg::REGION_NONE;
    if (sel_addr >= mesh_pkg::L2_BASE && sel_addr < L2_END)
      sel_region = mesh_pkg::REGION_L2;
    else if (sel_addr >= mesh_pkg::MBOX_BASE && sel_addr < MBOX_END)
      sel_region = mesh_pkg::REGION_MBOX;
  end

  // Target strobes, unmapped accesses reach neither side
  assign mem_en_o     = gnt_any && (sel_region == mesh_pkg::REGION_L2);
  assign mem_we_o     = tile_we_i[gnt_idx];
  assign mem_addr_o   = l2_off[MEM_W+1:2];  // Byte to word
  assign mem_wdata_o  = tile_wdata_i[gnt_idx];

  assign mbox_en_o    = gnt_any && (sel_region == mesh_pkg::REGION_MBOX);
  assign mbox_we_o    = tile_we_i[gnt_idx];
  assign mbox_idx_o   = mbox_off[IDX_W+1:2];
  assign mbox_wdata_o = tile_wdata_i[gnt_idx];
  assign mbox_tile_o  = gnt_idx;             // Tags character output

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q     <= '1;  // Tile 0 wins first
      acc_q        <= 1'b0;
      rd_q         <= 1'b0;
      ret_tile_q   <= '0;
      ret_region_q <= mesh_pkg::REGION_NONE;
    end else begin
      acc_q <= gnt_any;
      if (gnt_any) begin
        rr_ptr_q     <= gnt_idx;
        rd_q         <= !tile_we_i[gnt_idx];
        ret_tile_q   <= gnt_idx;
        ret_region_q <= sel_region;
      end
    end
  end

  // Pick the responding target
  always_comb begin
    case (ret_region_q)
      mesh_pkg::REGION_L2:   ret_data = mem_rdata_i;
      mesh_pkg::REGION_MBOX: ret_data = mbox_rdata_i;
      default:               ret_data = mesh_pkg::BAD_RDATA;
    endcase
  end

  // Steer back to the tile granted last cycle, err also flags dropped writes
  always_comb begin
    for (int i = 0; i < int'(N_TILES); i++) begin
      tile_rvalid_o[i] = acc_q && rd_q && (ret_tile_q == TW'(i));
      tile_err_o[i]    = acc_q && (ret_region_q == mesh_pkg::REGION_NONE) &&
                         (ret_tile_q == TW'(i));
      tile_rdata_o[i]  = ret_data;  // Qualified by rvalid
    end
  end

endmodule

`default_nettype wire
